// File: build.f
+incdir+rtl
rtl/job_pkg.sv
rtl/regmap_pkg.sv
rtl/job_tracker.sv
rtl/param_store.sv
rtl/read_mux.sv
rtl/ctrl_regfile_top.sv
testbench/tb_ctrl_regfile.sv

// File: Makefile
# Verilator run of the control register file testbench, make help lists the targets

TOP := tb_ctrl_regfile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the trace and search the log for the pass line"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/ctrl_regfile_trace.txt
# T name | W addr data | X addr (random data) | R addr expected | Q addr (expected from model)
# D done pulse | S ctx (wait for start) | P word ctx (params_o against model) | C clear, all hex
T acquire_pending
R 01 00000000
R 01 FFFFFFFE
T params_rw
X 08
X 09
X 0A
X 0B
X 18
X 19
X 1A
X 1B
Q 08
Q 09
Q 0A
Q 0B
Q 18
Q 19
Q 1A
Q 1B
T start_first
W 00 00000000
S 0
R 03 00000001
P 0 0
T acquire_busy
R 01 00000001
W 00 00000000
R 01 FFFFFFFF
P 2 0
T start_done
D
S 1
R 03 00000100
P 0 1
P 3 1
T finished
D
R 01 00000002
W 00 00000000
S 0
D
R 02 00000002
R 02 00000000
R 04 00000003
T unmapped_clear
R 06 DEADBEEF
C
R 01 00000000
R 03 00000000
Q 18

// File: testbench/tb_ctrl_regfile.sv
// Trace-driven testbench of the control register file that the Makefile in the root builds and runs
`include "ctrl_regfile_macros.svh"

module tb_ctrl_regfile;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    TIMEOUT_CYC = 50;
  localparam string TRACE_FILE  = "testbench/ctrl_regfile_trace.txt";

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clear_i;
  logic                  req_i;
  logic                  wren_i;
  regmap_pkg::reg_addr_u addr_i;
  regmap_pkg::reg_word_t wdata_i;
  logic                  done_i;
  regmap_pkg::reg_word_t rdata_o;
  logic                  rvalid_o;
  logic                  start_o;
  job_pkg::ctx_t         start_ctx_o;
  regmap_pkg::reg_word_t [`CTRL_N_PARAMS-1:0] params_o;

  // Expected parameter words as the random writes left them
  regmap_pkg::reg_word_t param_model [`CTRL_N_CONTEXT][`CTRL_N_PARAMS];
  logic [31:0] lfsr_state;
  string       test_name;
  int          test_errs;
  int          n_tests;
  int          n_bad_tests;
  int          n_checks;
  int          n_errs;
  logic        timed_out;

  ctrl_regfile_top dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .req_i       (req_i),
    .wren_i      (wren_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .done_i      (done_i),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o),
    .start_o     (start_o),
    .start_ctx_o (start_ctx_o),
    .params_o    (params_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Galois step that shifts right and folds in the feedback mask when bit 0 drops out
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_word(output regmap_pkg::reg_word_t w);
    w = '0;
    for (int i = 0; i < `CTRL_DATA_W; i++) begin
      w = {w[`CTRL_DATA_W-2:0], lfsr_state[0]};  // One step per bit taken
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic clear_model();
    for (int c = 0; c < `CTRL_N_CONTEXT; c++) begin
      for (int w = 0; w < `CTRL_N_PARAMS; w++) begin
        param_model[c][w] = '0;
      end
    end
  endtask

  task automatic check_word(input string what, input regmap_pkg::reg_word_t exp,
                            input regmap_pkg::reg_word_t act);
    n_checks++;
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
      n_errs++;
    end
  endtask

  task automatic check_ctx(input string what, input job_pkg::ctx_t exp, input job_pkg::ctx_t act);
    n_checks++;
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      test_errs++;
      n_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Test %s: %s", test_name, msg);
    test_errs++;
    n_errs++;
  endtask

  task automatic report_timeout(input string what);
    report_error($sformatf("no %s within %0d cycles", what, TIMEOUT_CYC));
    timed_out = 1'b1;
  endtask

  task automatic close_test();
    if (test_name != "") begin
      n_tests++;
      if (test_errs == 0) begin
        $display("Test %s ok", test_name);
      end else begin
        $display("Test %s had %0d error(s)", test_name, test_errs);
        n_bad_tests++;
      end
    end
  endtask

  task automatic host_write(input logic [7:0] addr, input regmap_pkg::reg_word_t data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    wren_i  <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
    @(posedge clk_i);
    req_i   <= 1'b0;
    wren_i  <= 1'b0;
  endtask

  task automatic host_read(input logic [7:0] addr, output regmap_pkg::reg_word_t data);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    req_i  <= 1'b1;
    wren_i <= 1'b0;
    addr_i <= addr;
    @(posedge clk_i);
    req_i  <= 1'b0;
    do begin
      @(negedge clk_i);   // Response is stable mid-cycle
      cycles++;
    end while (!rvalid_o && cycles < TIMEOUT_CYC);
    data = rdata_o;
    if (!rvalid_o) begin
      report_timeout("read response");
    end else begin
      if (cycles != 1) begin
        report_error($sformatf("read response came after %0d cycles instead of 1", cycles));
      end
      @(negedge clk_i);
      if (rvalid_o) report_error("rvalid_o stayed high for more than one cycle");
    end
  endtask

  task automatic wait_start(output job_pkg::ctx_t ctx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!start_o && cycles < TIMEOUT_CYC);
    ctx = start_ctx_o;
    if (!start_o) begin
      report_timeout("start strobe");
    end else if (cycles != 1) begin
      report_error($sformatf("start_o came after %0d cycles instead of 1", cycles));
    end
  endtask

  task automatic pulse_done();
    @(posedge clk_i);
    done_i <= 1'b1;
    @(posedge clk_i);
    done_i <= 1'b0;
  endtask

  task automatic pulse_clear();
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
  endtask

  initial begin
    int                    fd;
    string                 line;
    logic [7:0]            opc;
    logic [31:0]           a;
    logic [31:0]           b;
    regmap_pkg::reg_word_t word;
    job_pkg::ctx_t         ctx;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    req_i       = 1'b0;
    wren_i      = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    done_i      = 1'b0;
    lfsr_state  = 32'h8200;
    test_name   = "";
    test_errs   = 0;
    n_tests     = 0;
    n_bad_tests = 0;
    n_checks    = 0;
    n_errs      = 0;
    timed_out   = 1'b0;
    clear_model();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the trace file %s", TRACE_FILE);
      n_errs++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        a = '0;
        b = '0;
        opc = 8'h20;
        void'($sscanf(line, "%c %h %h", opc, a, b));
        case (opc)
          "T": begin
            close_test();
            void'($sscanf(line, "%c %s", opc, test_name));
            test_errs = 0;
          end
          "W": host_write(a[7:0], b);
          "X": begin
            draw_word(word);
            param_model[a[4]][a[1:0]] = word;   // Context bit sits above the index
            host_write(a[7:0], word);
          end
          "R": begin
            host_read(a[7:0], word);
            if (!timed_out) check_word($sformatf("read %h", a[7:0]), b, word);
          end
          "Q": begin
            host_read(a[7:0], word);
            if (!timed_out) begin
              check_word($sformatf("read %h", a[7:0]), param_model[a[4]][a[1:0]], word);
            end
          end
          "D": pulse_done();
          "S": begin
            wait_start(ctx);
            if (!timed_out) check_ctx("start context", job_pkg::ctx_t'(a), ctx);
          end
          "P": begin
            @(negedge clk_i);
            check_word($sformatf("params_o[%0d]", a[1:0]), param_model[b[0]][a[1:0]],
                       params_o[a[1:0]]);
          end
          "C": begin
            pulse_clear();
            clear_model();
          end
          "#", 8'h0A, 8'h0D, 8'h20: begin
          end
          default: begin
            $display("Unknown operation in the trace line: %s", line);
            n_errs++;
          end
        endcase
      end
      $fclose(fd);
      close_test();
    end
    $display("Tests: %0d, with errors: %0d, checks: %0d, errors: %0d",
             n_tests, n_bad_tests, n_checks, n_errs);
    if (n_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: rtl/ctrl_regfile_top.sv
// Control register file of the accelerator: host strobe bus on one side, engine on the other
`include "ctrl_regfile_macros.svh"

module ctrl_regfile_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        req_i,
  input  logic                                        wren_i,
  input  regmap_pkg::reg_addr_u                       addr_i,
  input  regmap_pkg::reg_word_t                       wdata_i,
  input  logic                                        done_i,
  output regmap_pkg::reg_word_t                       rdata_o,
  output logic                                        rvalid_o,
  output logic                                        start_o,
  output job_pkg::ctx_t                               start_ctx_o,
  output regmap_pkg::reg_word_t [`CTRL_N_PARAMS-1:0] params_o
);

  regmap_pkg::reg_word_t jt_rdata;
  regmap_pkg::reg_word_t ps_rdata;
  logic                  jt_rhit;
  logic                  ps_rhit;
  job_pkg::ctx_t         running_ctx;

  // Mandatory registers and job bookkeeping
  job_tracker u_job_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .req_i         (req_i),
    .wren_i        (wren_i),
    .addr_i        (addr_i),
    .done_i        (done_i),
    .rdata_o       (jt_rdata),
    .rhit_o        (jt_rhit),
    .start_o       (start_o),
    .start_ctx_o   (start_ctx_o),
    .running_ctx_o (running_ctx)
  );

  param_store u_param_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .req_i         (req_i),
    .wren_i        (wren_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .running_ctx_i (running_ctx),
    .rdata_o       (ps_rdata),
    .rhit_o        (ps_rhit),
    .params_o      (params_o)
  );

  read_mux u_read_mux (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .req_i      (req_i),
    .wren_i     (wren_i),
    .jt_rdata_i (jt_rdata),
    .ps_rdata_i (ps_rdata),
    .jt_rhit_i  (jt_rhit),
    .ps_rhit_i  (ps_rhit),
    .rdata_o    (rdata_o),
    .rvalid_o   (rvalid_o)
  );

endmodule

// File: rtl/read_mux.sv
// Registers the host read response from whichever block claimed the index
`include "ctrl_regfile_macros.svh"

module read_mux (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  req_i,
  input  logic                  wren_i,
  input  regmap_pkg::reg_word_t jt_rdata_i,
  input  regmap_pkg::reg_word_t ps_rdata_i,
  input  logic                  jt_rhit_i,
  input  logic                  ps_rhit_i,
  output regmap_pkg::reg_word_t rdata_o,
  output logic                  rvalid_o
);

  regmap_pkg::reg_word_t rdata_q;
  logic                  rvalid_q;
  logic                  rd;

  assign rd = req_i & ~wren_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (clear_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd;   // One response per read, no stall
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      if (jt_rhit_i) rdata_q <= jt_rdata_i;
      else if (ps_rhit_i) rdata_q <= ps_rdata_i;
      else rdata_q <= `CTRL_UNMAPPED;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

// File: rtl/param_store.sv
// Per-context job parameter words, written and read by the host and shown to the engine
`include "ctrl_regfile_macros.svh"

module param_store (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        req_i,
  input  logic                                        wren_i,
  input  regmap_pkg::reg_addr_u                       addr_i,
  input  regmap_pkg::reg_word_t                       wdata_i,
  input  job_pkg::ctx_t                               running_ctx_i,
  output regmap_pkg::reg_word_t                       rdata_o,
  output logic                                        rhit_o,
  output regmap_pkg::reg_word_t [`CTRL_N_PARAMS-1:0] params_o
);

  localparam int unsigned PW = $clog2(`CTRL_N_PARAMS);

  // One row of parameter words per context
  regmap_pkg::reg_word_t [`CTRL_N_PARAMS-1:0] params_q [`CTRL_N_CONTEXT];

  logic [`CTRL_IDX_W-1:0] idx;
  logic [`CTRL_IDX_W-1:0] offs;
  logic [PW-1:0]          word;
  job_pkg::ctx_t          ctx;
  logic                   hit;
  logic                   we;

  assign idx  = addr_i.cx.idx;
  assign ctx  = addr_i.cx.ctx;
  assign offs = idx - `CTRL_REG_PARAM0;
  assign word = offs[PW-1:0];

  // Indices below the window wrap to large offsets and miss
  assign hit = (offs < `CTRL_IDX_W'(`CTRL_N_PARAMS));
  assign we  = req_i & wren_i & hit;

  // Parameters return to zero on clear together with the job state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < `CTRL_N_CONTEXT; c++) begin
        params_q[c] <= '0;
      end
    end else if (clear_i) begin
      for (int c = 0; c < `CTRL_N_CONTEXT; c++) begin
        params_q[c] <= '0;
      end
    end else if (we) begin
      params_q[ctx][word] <= wdata_i;
    end
  end

  assign rdata_o = params_q[ctx][word];
  assign rhit_o  = hit;

  assign params_o = params_q[running_ctx_i];  // Engine sees only the running job

endmodule

// File: rtl/job_tracker.sv
// Acquire, trigger, status and finished count of the register file, plus the engine start strobe
`include "ctrl_regfile_macros.svh"

module job_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  req_i,
  input  logic                  wren_i,
  input  regmap_pkg::reg_addr_u addr_i,
  input  logic                  done_i,
  output regmap_pkg::reg_word_t rdata_o,
  output logic                  rhit_o,
  output logic                  start_o,
  output job_pkg::ctx_t         start_ctx_o,
  output job_pkg::ctx_t         running_ctx_o
);

  localparam int unsigned CW = $bits(job_pkg::ctx_t);

  job_pkg::job_id_t  offload_id_q;
  job_pkg::job_id_t  running_id_q;
  job_pkg::job_id_t  last_id;
  job_pkg::status_t  status_q;
  job_pkg::fin_cnt_t fin_cnt_q;
  logic              pending_q;
  logic              running_q;
  logic              start_q;

  job_pkg::ctx_t             ptr_ctx;
  job_pkg::ctx_t             run_ctx;
  job_pkg::ctx_t             next_ctx;
  logic [`CTRL_N_CONTEXT-1:0] busy;
  logic [`CTRL_IDX_W-1:0]    idx;
  logic rd;
  logic acq_ok;
  logic trig_ok;
  logic fin_rd;
  logic done_ok;
  logic all_busy;
  logic next_busy;
  logic start_d;

  assign idx     = addr_i.flat.idx;
  assign rd      = req_i & ~wren_i;
  assign fin_rd  = rd && (idx == `CTRL_REG_FINISHED);
  assign trig_ok = req_i && wren_i && (idx == `CTRL_REG_TRIGGER) && pending_q;

  assign last_id  = offload_id_q - job_pkg::job_id_t'(1);
  assign ptr_ctx  = last_id[CW-1:0];       // Context of the job handed out by the last acquire
  assign run_ctx  = running_id_q[CW-1:0];
  assign next_ctx = run_ctx + job_pkg::ctx_t'(1);

  always_comb begin
    for (int c = 0; c < `CTRL_N_CONTEXT; c++) begin
      busy[c] = status_q[c][0];
    end
  end

  assign all_busy = &busy;
  assign acq_ok   = rd && (idx == `CTRL_REG_ACQUIRE) && !pending_q && !all_busy;
  assign done_ok  = done_i & running_q;    // Stray done with nothing running is ignored

  // A trigger landing with the done still hands the engine the next context
  assign next_busy = busy[next_ctx] | (trig_ok && (ptr_ctx == next_ctx));
  assign start_d   = (trig_ok & ~running_q) | (done_ok & next_busy);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q <= '0;
      pending_q    <= 1'b0;
    end else if (clear_i) begin
      offload_id_q <= '0;
      pending_q    <= 1'b0;
    end else if (acq_ok) begin
      offload_id_q <= offload_id_q + job_pkg::job_id_t'(1);
      pending_q    <= 1'b1;
    end else if (trig_ok) begin
      pending_q    <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_id_q <= '0;
      running_q    <= 1'b0;
      start_q      <= 1'b0;
    end else if (clear_i) begin
      running_id_q <= '0;
      running_q    <= 1'b0;
      start_q      <= 1'b0;
    end else begin
      if (done_ok) running_id_q <= running_id_q + job_pkg::job_id_t'(1);
      running_q <= start_d | (running_q & ~done_ok);
      start_q   <= start_d;
    end
  end

  // Unused upper bytes keep their reset value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else if (clear_i) begin
      status_q <= '0;
    end else begin
      for (int c = 0; c < `CTRL_N_CONTEXT; c++) begin
        if (trig_ok && (ptr_ctx == job_pkg::ctx_t'(c))) begin
          status_q[c] <= job_pkg::STATUS_BUSY;
        end else if (done_ok && (run_ctx == job_pkg::ctx_t'(c))) begin
          status_q[c] <= job_pkg::STATUS_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fin_cnt_q <= '0;
    end else if (clear_i) begin
      fin_cnt_q <= '0;
    end else if (fin_rd) begin
      fin_cnt_q <= done_ok ? job_pkg::fin_cnt_t'(1) : '0;  // A done during the read still counts
    end else if (done_ok && (fin_cnt_q != job_pkg::FIN_MAX)) begin
      fin_cnt_q <= fin_cnt_q + job_pkg::fin_cnt_t'(1);
    end
  end

  // Read words are formed from the state before this cycle's update
  always_comb begin
    rdata_o = '0;
    rhit_o  = 1'b1;
    case (idx)
      `CTRL_REG_TRIGGER: rdata_o = '0;  // Write-only
      `CTRL_REG_ACQUIRE: begin
        if (pending_q) rdata_o = `CTRL_RESP_OFFLOADING;
        else if (all_busy) rdata_o = `CTRL_RESP_ALL_BUSY;
        else rdata_o = regmap_pkg::reg_word_t'(offload_id_q);
      end
      `CTRL_REG_FINISHED: rdata_o = regmap_pkg::reg_word_t'(fin_cnt_q);
      `CTRL_REG_STATUS:   rdata_o = status_q;
      `CTRL_REG_RUNNING:  rdata_o = regmap_pkg::reg_word_t'(running_id_q);
      default:            rhit_o  = 1'b0;
    endcase
  end

  assign start_o       = start_q;
  assign start_ctx_o   = run_ctx;   // Already advanced when start follows a done
  assign running_ctx_o = run_ctx;

endmodule

// File: rtl/regmap_pkg.sv
// Host-visible address space of the register file: data word and the two views of an address
`include "ctrl_regfile_macros.svh"

package regmap_pkg;

  localparam int unsigned ADDR_W = 8;  // Word address bits seen by the register file
  localparam int unsigned CTX_W  = $bits(job_pkg::ctx_t);

  typedef logic [`CTRL_DATA_W-1:0] reg_word_t;

  // Mandatory registers are picked by the index alone
  typedef struct packed {
    logic [ADDR_W-`CTRL_IDX_W-1:0] unused;
    logic [`CTRL_IDX_W-1:0]        idx;
  } addr_flat_t;

  // Parameter words carry the context right above the index
  typedef struct packed {
    logic [ADDR_W-`CTRL_IDX_W-CTX_W-1:0] unused;
    job_pkg::ctx_t                       ctx;
    logic [`CTRL_IDX_W-1:0]              idx;
  } addr_ctx_t;

  // The index field selects which view applies
  typedef union packed {
    addr_flat_t flat;
    addr_ctx_t  cx;
  } reg_addr_u;

endpackage

// File: rtl/job_pkg.sv
// Job bookkeeping types shared by the job tracker, the parameter store and the address map
`include "ctrl_regfile_macros.svh"

package job_pkg;

  typedef logic [7:0] job_id_t;

  typedef logic [$clog2(`CTRL_N_CONTEXT)-1:0] ctx_t;

  // One byte per context, bit 0 of a byte means busy
  typedef logic [3:0][7:0] status_t;

  typedef logic [1:0] fin_cnt_t;

  localparam fin_cnt_t   FIN_MAX     = 2'd2;  // Finished counter saturates here
  localparam logic [7:0] STATUS_BUSY = 8'h01;
  localparam logic [7:0] STATUS_IDLE = 8'h00;

endpackage

// File: rtl/ctrl_regfile_macros.svh
// Fixed sizing, register indices and response codes of the register file, included by all RTL
`ifndef CTRL_REGFILE_MACROS_SVH
`define CTRL_REGFILE_MACROS_SVH

`define CTRL_DATA_W    32
`define CTRL_N_CONTEXT 2
`define CTRL_N_PARAMS  4   // Parameter words per context
`define CTRL_IDX_W     4   // Register index field of a word address

// Mandatory registers
`define CTRL_REG_TRIGGER  4'd0
`define CTRL_REG_ACQUIRE  4'd1
`define CTRL_REG_FINISHED 4'd2
`define CTRL_REG_STATUS   4'd3
`define CTRL_REG_RUNNING  4'd4

`define CTRL_REG_PARAM0   4'd8   // First parameter word, context bit sits above the index

// Acquire responses
`define CTRL_RESP_OFFLOADING 32'hFFFF_FFFE  // Another acquire waits for its trigger
`define CTRL_RESP_ALL_BUSY   32'hFFFF_FFFF

`define CTRL_UNMAPPED 32'hDEAD_BEEF

`endif
